/* build.f */
src/scct_timer_pkg.sv
src/scct_reg_pkg.sv
src/scct_counter.sv
src/scct_channel.sv
src/scct_wb_regs.sv
src/scct_top.sv
bench/tb_scct.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_scct
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\* FAIL \*\*' $(LOG); then \
	   echo "test failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_scct.sv */
/*
 * scct testbench
 * exercises registers, counter, compare, capture, overflow and interrupt masking
 */
`timescale 1ns/1ps

module tb_scct
   import scct_timer_pkg::*, scct_reg_pkg::*;
();

   localparam int unsigned WB_TIMEOUT = 20;
   localparam int unsigned NUM_ROWS   = 10;
   localparam int unsigned CTR_STEPS  = 10;

   // register, write value, expected read-back, mask of implemented bits
   typedef struct {
      int unsigned      adr;
      logic [DAT_W-1:0] wdat;
      logic [DAT_W-1:0] exp;
      logic [DAT_W-1:0] mask;
   } row_t;

   logic              clk;
   logic              rst;
   logic              wb_cyc;
   logic              wb_stb;
   logic              wb_we;
   logic [ADR_W-1:0]  wb_adr;
   logic [DAT_W-1:0]  wb_wdat;
   logic [DAT_W-1:0]  wb_rdat;
   logic              wb_ack;
   logic [NUM_CH-1:0] pins_i;
   logic [NUM_CH-1:0] pins_o;
   logic              irq;
   logic [31:0]       rng_q;
   row_t              rows [NUM_ROWS];
   int                checks;
   int                mismatches;
   int                failures;

   scct_top i_dut (
      .clk      (clk),
      .rst      (rst),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_we_i  (wb_we),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_wdat),
      .wb_dat_o (wb_rdat),
      .wb_ack_o (wb_ack),
      .pins_i   (pins_i),
      .pins_o   (pins_o),
      .irq_o    (irq)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_q;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_q = x;
      return x;
   endfunction

   // unmapped registers expect zero whatever was written
   function automatic row_t make_row(input int unsigned adr, input logic [DAT_W-1:0] mask,
                                     input logic mapped);
      row_t r;
      r.adr  = adr;
      r.wdat = next_random();
      r.exp  = mapped ? r.wdat : '0;
      r.mask = mask;
      return r;
   endfunction

   task automatic compare(input string name, input logic [DAT_W-1:0] got,
                          input logic [DAT_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      end
   endtask

   // one classic cycle held until ack or timeout
   task automatic bus_cycle(input logic we, input int unsigned adr,
                            input logic [DAT_W-1:0] wdat, output logic [DAT_W-1:0] rdat);
      int unsigned n;
      n = 0;
      @(posedge clk);
      wb_cyc  <= 1'b1;
      wb_stb  <= 1'b1;
      wb_we   <= we;
      wb_adr  <= ADR_W'(adr);
      wb_wdat <= wdat;
      @(negedge clk);
      while (!wb_ack && n < WB_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      rdat = wb_rdat;
      if (!wb_ack) begin
         $display("no ack from bus at register %0d, time %0t", adr, $time);
         failures++;
         rdat = '0;
      end
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input int unsigned adr, input logic [DAT_W-1:0] dat);
      logic [DAT_W-1:0] unused;
      bus_cycle(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input int unsigned adr, output logic [DAT_W-1:0] dat);
      bus_cycle(1'b0, adr, '0, dat);
   endtask

   task automatic wait_irq(input int unsigned limit, input string what);
      int unsigned n;
      n = 0;
      @(negedge clk);
      while (!irq && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (!irq) begin
         $display("irq_o never rose while waiting for %s", what);
         failures++;
      end
   endtask

   // polls the channel status register
   task automatic wait_ch_status(input int unsigned ch, input int unsigned limit);
      logic [DAT_W-1:0] st;
      int unsigned      n;
      n = 0;
      wb_read(REG_CH_IS, st);
      while (!st[ch] && n < limit) begin
         wb_read(REG_CH_IS, st);
         n++;
      end
      if (!st[ch]) begin
         $display("status of channel %0d was never set", ch);
         failures++;
      end
   endtask

   initial begin
      logic [DAT_W-1:0] rd;
      logic [DAT_W-1:0] c0;
      logic [DAT_W-1:0] c1;
      logic [DAT_W-1:0] v;
      logic [DAT_W-1:0] pin_before;
      logic             exp_pin;
      int unsigned      p;
      rst        = 1'b1;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_wdat    = '0;
      pins_i     = '0;
      rng_q      = 32'd65388;
      checks     = 0;
      mismatches = 0;
      failures   = 0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      rows[0] = make_row(REG_PSC, 32'h0000_ffff, 1'b1);
      rows[1] = make_row(REG_CH_MODE, 32'h0000_000f, 1'b1);
      rows[2] = make_row(REG_CH_ACT, 32'h0000_00ff, 1'b1);
      rows[3] = make_row(REG_CH_IE, 32'h0000_000f, 1'b1);
      for (int n = 0; n < NUM_CH; n++) begin
         rows[4+n] = make_row(REG_CCR0 + n, 32'hffff_ffff, 1'b1);
      end
      rows[8] = make_row(14, 32'hffff_ffff, 1'b0);
      rows[9] = make_row(15, 32'hffff_ffff, 1'b0);
      for (int i = 0; i < NUM_ROWS; i++) begin
         wb_write(rows[i].adr, rows[i].wdat);
         wb_read(rows[i].adr, rd);
         compare($sformatf("read-back reg %0d", rows[i].adr), rd & rows[i].mask,
                 rows[i].exp & rows[i].mask);
      end
      wb_write(REG_CH_MODE, '0);
      wb_write(REG_CH_ACT, '0);
      wb_write(REG_CH_IE, '0);
      wb_write(REG_CH_IS, 32'hf);

      // counter steps once every p+1 clocks
      p = 2 + (next_random() % 4);
      wb_write(REG_PSC, p);
      wb_read(REG_CTR, c0);
      repeat (CTR_STEPS * (p + 1)) @(posedge clk);
      wb_read(REG_CTR, c1);
      rd = c1 - c0;
      compare("ctr steps", rd, (rd >= CTR_STEPS - 1 && rd <= CTR_STEPS + 1) ? rd : CTR_STEPS);
      v = next_random() & 32'h0fff_ffff;
      wb_write(REG_CTR, v);
      wb_read(REG_CTR, rd);
      compare("ctr load", rd, (rd == v + 1) ? rd : v);

      // output compare toggles channel 1
      wb_write(REG_PSC, '0);
      wb_write(REG_CH_ACT, DAT_W'(ACT_TGL) << 2);
      wb_read(REG_CH_OUT, pin_before);
      exp_pin = ~pin_before[1];
      wb_read(REG_CTR, c0);
      wb_write(REG_CCR0 + 1, c0 + 40);
      wb_write(REG_CH_IE, 32'h2);
      wait_irq(100, "compare on channel 1");
      wb_read(REG_CH_OUT, rd);
      compare("ch1 out reg", rd[1], exp_pin);
      @(negedge clk);
      compare("pins_o[1]", pins_o[1], exp_pin);
      wb_read(REG_CH_IS, rd);
      compare("ch1 status", rd[1], 1'b1);
      wb_write(REG_CH_IS, 32'h2);
      @(negedge clk);
      compare("irq_o after ch1 clear", irq, 1'b0);
      wb_read(REG_CH_IS, rd);
      compare("ch1 status after clear", rd[1], 1'b0);
      wb_write(REG_CH_IE, '0);

      // input capture on channel 2
      wb_write(REG_CH_MODE, 32'h4);
      wb_read(REG_CTR, c0);
      @(posedge clk);
      pins_i <= 4'b0100;
      wait_ch_status(2, 10);
      wb_read(REG_CTR, c1);
      wb_read(REG_CCR0 + 2, rd);
      compare("ccr2 capture", rd, (rd >= c0 && rd <= c1) ? rd : c0);
      wb_read(REG_CH_IS, rd);
      compare("ch2 status", rd[2], 1'b1);
      wb_read(REG_CH_INP, rd);
      compare("pin inputs", rd, 32'h4);
      @(posedge clk);
      pins_i <= '0;
      wb_write(REG_CH_IS, 32'h4);
      wb_write(REG_CH_MODE, '0);

      // overflow from the maximum count
      wb_write(REG_CTR_IE, 32'h1);
      wb_write(REG_CTR, 32'hffff_ffff);
      wait_irq(20, "counter overflow");
      wb_read(REG_CTR_IS, rd);
      compare("overflow status", rd, 32'h1);
      wb_write(REG_CTR_IS, 32'h1);
      @(negedge clk);
      compare("irq_o after overflow clear", irq, 1'b0);

      // channel 3 sets its status with the enable clear
      wb_write(REG_CH_ACT, '0);
      wb_read(REG_CTR, c0);
      wb_write(REG_CCR0 + 3, c0 + 20);
      wait_ch_status(3, 20);
      @(negedge clk);
      compare("irq_o with ch3 masked", irq, 1'b0);
      wb_read(REG_CH_IS, rd);
      compare("ch3 status masked", rd[3], 1'b1);

      $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* src/scct_top.sv */
/*
 * scct top level
 * capture/compare timer behind a Wishbone classic slave port
 */
`timescale 1ns/1ps

module scct_top
   import scct_timer_pkg::*, scct_reg_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              wb_cyc_i,
   input  logic              wb_stb_i,
   input  logic              wb_we_i,
   input  logic [ADR_W-1:0]  wb_adr_i,
   input  logic [DAT_W-1:0]  wb_dat_i,
   output logic [DAT_W-1:0]  wb_dat_o,
   output logic              wb_ack_o,
   input  logic [NUM_CH-1:0] pins_i,
   output logic [NUM_CH-1:0] pins_o,
   output logic              irq_o
);

   wr_bus_t                wr;
   ctr_state_t             ctr_st;
   ch_state_t [NUM_CH-1:0] ch_st;

   scct_wb_regs i_regs (
      .clk      (clk),
      .rst      (rst),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .wr_o     (wr),
      .ctr_i    (ctr_st),
      .ch_i     (ch_st),
      .pins_i   (pins_i),
      .irq_o    (irq_o)
   );

   scct_counter i_counter (
      .clk     (clk),
      .rst     (rst),
      .wr_i    (wr),
      .state_o (ctr_st)
   );

   // one channel per pin
   for (genvar n = 0; n < NUM_CH; n++) begin : g_ch
      scct_channel #(
         .CH_IDX (n)
      ) i_channel (
         .clk     (clk),
         .rst     (rst),
         .wr_i    (wr),
         .ctr_i   (ctr_st),
         .pin_i   (pins_i[n]),
         .state_o (ch_st[n])
      );

      assign pins_o[n] = ch_st[n].pin;
   end

endmodule

/* src/scct_wb_regs.sv */
/*
 * scct bus block
 * Wishbone classic slave, write strobe decode, read mux and interrupt combine
 */
`timescale 1ns/1ps

module scct_wb_regs
   import scct_timer_pkg::*, scct_reg_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    wb_cyc_i,
   input  logic                    wb_stb_i,
   input  logic                    wb_we_i,
   input  logic [ADR_W-1:0]        wb_adr_i,
   input  logic [DAT_W-1:0]        wb_dat_i,
   output logic [DAT_W-1:0]        wb_dat_o,
   output logic                    wb_ack_o,
   output wr_bus_t                 wr_o,
   input  ctr_state_t              ctr_i,
   input  ch_state_t [NUM_CH-1:0]  ch_i,
   input  logic [NUM_CH-1:0]       pins_i,
   output logic                    irq_o
);

   logic                ack_q;
   logic [NUM_REG-1:0]  sel_q;
   logic [DAT_W-1:0]    wdat_q;
   logic [DAT_W-1:0]    rdat_q;
   logic                req;
   logic [NUM_REG-1:0]  dec;
   logic [DAT_W-1:0]    rd_mux;
   logic [NUM_CH-1:0]   mode_v;
   logic [2*NUM_CH-1:0] act_v;
   logic [NUM_CH-1:0]   ie_v;
   logic [NUM_CH-1:0]   is_v;
   logic [NUM_CH-1:0]   out_v;

   // a new access gets ack in the following cycle
   assign req = wb_cyc_i && wb_stb_i && !ack_q;

   // gather per-channel fields into register images
   always_comb begin
      for (int n = 0; n < NUM_CH; n++) begin
         mode_v[n]      = ch_i[n].mode;
         act_v[2*n +: 2] = ch_i[n].act;
         ie_v[n]        = ch_i[n].ie;
         is_v[n]        = ch_i[n].is;
         out_v[n]       = ch_i[n].pin;
      end
   end

   // addresses past the map select nothing
   always_comb begin
      dec = '0;
      if (wb_adr_i < NUM_REG) begin
         dec[wb_adr_i] = 1'b1;
      end
   end

   always_comb begin
      rd_mux = '0;
      case (wb_adr_i)
         REG_CTR:     rd_mux = DAT_W'(ctr_i.ctr);
         REG_PSC:     rd_mux = DAT_W'(ctr_i.psc);
         REG_CTR_IE:  rd_mux = DAT_W'(ctr_i.ie);
         REG_CTR_IS:  rd_mux = DAT_W'(ctr_i.is);
         REG_CH_MODE: rd_mux = DAT_W'(mode_v);
         REG_CH_ACT:  rd_mux = DAT_W'(act_v);
         REG_CH_IE:   rd_mux = DAT_W'(ie_v);
         REG_CH_IS:   rd_mux = DAT_W'(is_v);
         REG_CH_INP:  rd_mux = DAT_W'(pins_i);
         REG_CH_OUT:  rd_mux = DAT_W'(out_v);
         default: begin
            if (wb_adr_i >= REG_CCR0 && wb_adr_i < NUM_REG) begin
               rd_mux = DAT_W'(ch_i[wb_adr_i - REG_CCR0].ccr);
            end
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ack_q  <= 1'b0;
         sel_q  <= '0;
         wdat_q <= '0;
         rdat_q <= '0;
      end else begin
         ack_q <= req;
         // strobe lines up with ack
         sel_q <= (req && wb_we_i) ? dec : '0;
         if (req && wb_we_i) begin
            wdat_q <= wb_dat_i;
         end
         if (req && !wb_we_i) begin
            rdat_q <= rd_mux;
         end
      end
   end

   assign wb_ack_o = ack_q;
   assign wb_dat_o = rdat_q;
   assign wr_o     = '{sel: sel_q, dat: wdat_q};

   assign irq_o = (ctr_i.ie & ctr_i.is) | (|(ie_v & is_v));

   a_ack_single: assert property (@(posedge clk) disable iff (rst)
      wb_ack_o |=> !wb_ack_o);

endmodule

/* src/scct_channel.sv */
/*
 * scct channel
 * one input-capture / output-compare channel with its own pin
 */
`timescale 1ns/1ps

module scct_channel
   import scct_timer_pkg::*, scct_reg_pkg::*;
#(
   parameter int unsigned CH_IDX = 0
) (
   input  logic       clk,
   input  logic       rst,
   input  wr_bus_t    wr_i,
   input  ctr_state_t ctr_i,
   input  logic       pin_i,
   output ch_state_t  state_o
);

   localparam int unsigned CCR_IDX = REG_CCR0 + CH_IDX;

   // [1:0] synchronizer, [2] previous level
   logic [2:0]       sync_q;
   logic             rise_q;
   logic             mode_q;
   logic [1:0]       act_q;
   logic [CTR_W-1:0] ccr_q;
   logic             ie_q;
   logic             is_q;
   logic             pin_q;
   logic             capture;
   logic             match;
   logic             is_clr;

   assign capture = mode_q && rise_q;
   // counter has just stepped onto CCR
   assign match   = !mode_q && ctr_i.tick && (ctr_i.ctr == ccr_q);
   assign is_clr  = wr_i.sel[REG_CH_IS] && wr_i.dat[CH_IDX];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sync_q <= '0;
         rise_q <= 1'b0;
      end else begin
         sync_q <= {sync_q[1:0], pin_i};
         rise_q <= sync_q[1] & ~sync_q[2];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         mode_q <= 1'b0;
         act_q  <= ACT_NONE;
         ccr_q  <= '0;
         ie_q   <= 1'b0;
         is_q   <= 1'b0;
         pin_q  <= 1'b0;
      end else begin
         if (wr_i.sel[REG_CH_MODE]) begin
            mode_q <= wr_i.dat[CH_IDX];
         end
         if (wr_i.sel[REG_CH_ACT]) begin
            act_q <= wr_i.dat[2*CH_IDX +: 2];
         end
         if (wr_i.sel[REG_CH_IE]) begin
            ie_q <= wr_i.dat[CH_IDX];
         end
         // a capture overrides a CCR write in the same cycle
         if (capture) begin
            ccr_q <= ctr_i.ctr;
         end else if (wr_i.sel[CCR_IDX]) begin
            ccr_q <= wr_i.dat[CTR_W-1:0];
         end
         if (match) begin
            case (act_q)
               ACT_SET: pin_q <= 1'b1;
               ACT_CLR: pin_q <= 1'b0;
               ACT_TGL: pin_q <= ~pin_q;
               default: pin_q <= pin_q;
            endcase
         end
         is_q <= (is_q & ~is_clr) | capture | match;
      end
   end

   assign state_o = '{mode: mode_q, act: act_q, ccr: ccr_q,
                      ie: ie_q, is: is_q, pin: pin_q};

   // pin holds its level for as long as the channel captures
   a_capture_pin_stable: assert property (@(posedge clk) disable iff (rst)
      mode_q |=> $stable(pin_q));

endmodule

/* src/scct_counter.sv */
/*
 * scct counter
 * prescaled free-running counter with bus load and overflow flag
 */
`timescale 1ns/1ps

module scct_counter
   import scct_timer_pkg::*, scct_reg_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  wr_bus_t    wr_i,
   output ctr_state_t state_o
);

   logic [PSC_W-1:0] psc_q;
   logic [PSC_W-1:0] pcnt_q;
   logic [CTR_W-1:0] ctr_q;
   logic             ie_q;
   logic             is_q;
   logic             tick_q;
   logic             step;
   logic             wrap;

   // >= so a smaller PSC written mid-count still ends the period
   assign step = (pcnt_q >= psc_q);
   assign wrap = step && (ctr_q == '1) && !wr_i.sel[REG_CTR];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         psc_q  <= '0;
         pcnt_q <= '0;
         ctr_q  <= '0;
         ie_q   <= 1'b0;
         is_q   <= 1'b0;
         tick_q <= 1'b0;
      end else begin
         if (wr_i.sel[REG_PSC]) begin
            psc_q <= wr_i.dat[PSC_W-1:0];
         end
         if (wr_i.sel[REG_CTR_IE]) begin
            ie_q <= wr_i.dat[0];
         end
         // bus load takes priority over a step
         if (wr_i.sel[REG_CTR]) begin
            ctr_q  <= wr_i.dat[CTR_W-1:0];
            pcnt_q <= '0;
            tick_q <= 1'b0;
         end else if (step) begin
            ctr_q  <= ctr_q + 1'b1;
            pcnt_q <= '0;
            tick_q <= 1'b1;
         end else begin
            pcnt_q <= pcnt_q + 1'b1;
            tick_q <= 1'b0;
         end
         // a wrap in the same cycle beats the write 1 to clear
         is_q <= (is_q & ~(wr_i.sel[REG_CTR_IS] & wr_i.dat[0])) | wrap;
      end
   end

   assign state_o = '{ctr: ctr_q, psc: psc_q, ie: ie_q, is: is_q, tick: tick_q};

   a_tick_spacing: assert property (@(posedge clk) disable iff (rst)
      (tick_q && psc_q != '0) |=> !tick_q);

endmodule

/* src/scct_reg_pkg.sv */
/*
 * scct register package
 * word-address map, bus widths and the internal write strobe
 */
package scct_reg_pkg;

   localparam int unsigned ADR_W = 4;
   localparam int unsigned DAT_W = 32;

   // word addresses
   localparam int unsigned REG_CTR     = 0;
   localparam int unsigned REG_PSC     = 1;
   localparam int unsigned REG_CTR_IE  = 2;
   localparam int unsigned REG_CTR_IS  = 3;
   localparam int unsigned REG_CH_MODE = 4;
   localparam int unsigned REG_CH_ACT  = 5;
   localparam int unsigned REG_CH_IE   = 6;
   localparam int unsigned REG_CH_IS   = 7;
   localparam int unsigned REG_CH_INP  = 8;
   localparam int unsigned REG_CH_OUT  = 9;
   // channel n sits at REG_CCR0 + n
   localparam int unsigned REG_CCR0    = 10;

   localparam int unsigned NUM_REG = 14;

   // one bus write valid for a single cycle
   typedef struct packed {
      // one-hot register select that is all zero when idle
      logic [NUM_REG-1:0] sel;
      logic [DAT_W-1:0]   dat;
   } wr_bus_t;

endpackage

/* src/scct_timer_pkg.sv */
/*
 * scct timer package
 * counter, prescaler and channel widths, output-compare actions, state records
 */
package scct_timer_pkg;

   localparam int unsigned CTR_W  = 32;
   localparam int unsigned PSC_W  = 16;
   localparam int unsigned NUM_CH = 4;

   // output-compare actions applied to the channel pin on a match
   localparam logic [1:0] ACT_NONE = 2'd0;
   localparam logic [1:0] ACT_SET  = 2'd1;
   localparam logic [1:0] ACT_CLR  = 2'd2;
   localparam logic [1:0] ACT_TGL  = 2'd3;

   // counter side as seen by the bus block and the channels
   typedef struct packed {
      logic [CTR_W-1:0] ctr;
      logic [PSC_W-1:0] psc;
      logic             ie;
      logic             is;
      // high for one cycle after each counter step
      logic             tick;
   } ctr_state_t;

   // one channel as seen by the bus block
   typedef struct packed {
      // 1 = input capture, 0 = output compare
      logic             mode;
      logic [1:0]       act;
      logic [CTR_W-1:0] ccr;
      logic             ie;
      logic             is;
      logic             pin;
   } ch_state_t;

endpackage
